//--- hw/sata_prim_pkg.sv
// SATA primitive dword codes and the continuable-primitive test, imported by the link stages
package sata_prim_pkg;

  // byte 0 carries the control character, K28.5 for ALIGN and K28.3 for the rest
  localparam logic [31:0] prim_align   = 32'h7b4a_4abc;
  localparam logic [31:0] prim_cont    = 32'h9999_aa7c;
  localparam logic [31:0] prim_sync    = 32'hb5b5_957c;
  localparam logic [31:0] prim_r_rdy   = 32'h4a4a_957c;
  localparam logic [31:0] prim_r_ip    = 32'h5555_b57c;
  localparam logic [31:0] prim_r_ok    = 32'h3535_b57c;
  localparam logic [31:0] prim_r_err   = 32'h5656_b57c;
  localparam logic [31:0] prim_x_rdy   = 32'h5757_b57c;
  localparam logic [31:0] prim_sof     = 32'h3737_b57c;
  localparam logic [31:0] prim_eof     = 32'hd5d5_b57c;
  localparam logic [31:0] prim_wtrm    = 32'h5858_b57c;
  localparam logic [31:0] prim_hold    = 32'hd5d5_aa7c;
  localparam logic [31:0] prim_holda   = 32'h9595_aa7c;
  localparam logic [31:0] prim_pmreq_s = 32'h7575_957c;
  localparam logic [31:0] prim_pmreq_p = 32'h1717_b57c;

  // primitives that a transmitter may replace by CONT when repeated
  // SOF, EOF, ALIGN and CONT itself are never continued
  function automatic logic is_contable(input logic [31:0] d);
    case (d)
      prim_sync,
      prim_r_rdy,
      prim_r_ip,
      prim_r_ok,
      prim_r_err,
      prim_x_rdy,
      prim_wtrm,
      prim_hold,
      prim_holda,
      prim_pmreq_s,
      prim_pmreq_p: begin
        return 1'b1;
      end
      default: begin
        return 1'b0;
      end
    endcase
  endfunction

endpackage

//--- hw/sata_link_pkg.sv
// link dword and detect vector types plus scrambler constants, shared by the link stages
package sata_link_pkg;

  // one dword on the link, isk[0] set means byte 0 is a control character
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  isk;
  } link_dword_t;

  // receive result, one flag per primitive plus the collision flag
  typedef struct packed {
    logic sync;
    logic r_rdy;
    logic r_ip;
    logic r_err;
    logic r_ok;
    logic x_rdy;
    logic sof;
    logic eof;
    logic wtrm;
    logic cont;
    logic hold;
    logic holda;
    logic pmreq_s;
    logic pmreq_p;
    logic align;
    logic xrdy_xrdy;  // both ends sending X_RDY
  } prim_detect_t;

  // junk generator, x^16+x^15+x^13+x^4+1 in Galois form
  localparam logic [15:0] scram_seed = 16'hffff;
  localparam logic [15:0] lfsr_taps  = 16'ha011;  // x^15, x^13, x^4, 1

endpackage

//--- hw/cont_scrambler.sv
// junk dword source for the CONT generator, advanced once per junk dword sent
module cont_scrambler (
  input  logic        clk,
  input  logic        rst,
  input  logic        scram_adv,  // junk consumed this cycle
  output logic [31:0] junk
);

  import sata_link_pkg::*;

  logic [15:0] lfsr;      // state one word ahead of junk
  logic [47:0] step_nxt;  // {next state, next word}

  // run the LFSR for 32 shifts, msb out first
  function automatic logic [47:0] step32(input logic [15:0] s_in);
    logic [15:0] s;
    logic [31:0] w;
    s = s_in;
    w = '0;
    for (int i = 31; i >= 0; i--) begin
      w[i] = s[15];
      s = {s[14:0], 1'b0} ^ (s[15] ? lfsr_taps : 16'h0000);
    end
    return {s, w};
  endfunction

  assign step_nxt = step32(lfsr);

  // the first word of the sequence comes straight from the seed
  always_ff @(posedge clk) begin
    if (rst) begin
      {lfsr, junk} <= step32(scram_seed);
    end else if (scram_adv) begin
      {lfsr, junk} <= step_nxt;  // present word is taken, line up the next
    end
  end

endmodule

//--- hw/cont_tx_gen.sv
// transmit stage that turns runs of repeated primitives into CONT followed by junk dwords
module cont_tx_gen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      phy_ready,     // dword accepted by the phy
  input  logic                      xmit_cont_en,
  input  logic                      last_prim,     // ends any run in progress
  input  sata_link_pkg::link_dword_t ll_tx,
  input  logic [31:0]               junk,
  output logic                      scram_adv,
  output sata_link_pkg::link_dword_t cont_tx
);

  import sata_prim_pkg::*;
  import sata_link_pkg::*;

  logic [31:0] prev_prim;  // last accepted tx data
  logic [1:0]  run_cnt;    // dwords of the current run so far, sticks at 3
  logic [1:0]  cnt_nxt;

  logic        contable;
  logic        run_hit;    // this dword extends the run
  logic        send_cont;
  logic        send_junk;

  link_dword_t tx_nxt;

  assign contable = ll_tx.isk[0] && is_contable(ll_tx.data);

  // prev_prim only counts once a run has started
  assign run_hit   = xmit_cont_en && !last_prim && contable &&
                     (run_cnt != 2'd0) && (ll_tx.data == prev_prim);
  assign send_cont = run_hit && (run_cnt == 2'd2);  // third of the run
  assign send_junk = run_hit && (run_cnt == 2'd3);  // fourth and later

  assign scram_adv = phy_ready && send_junk;

  always_comb begin
    tx_nxt = ll_tx;
    if (send_cont) begin
      tx_nxt.data = prim_cont;
      tx_nxt.isk  = 4'b0001;
    end else if (send_junk) begin
      tx_nxt.data = junk;
      tx_nxt.isk  = 4'b0000;  // junk goes out as plain data
    end
  end

  // run length bookkeeping
  always_comb begin
    if (!xmit_cont_en || last_prim || !contable) begin
      cnt_nxt = 2'd0;  // next dword starts over
    end else if (run_hit) begin
      cnt_nxt = (run_cnt == 2'd3) ? 2'd3 : run_cnt + 2'd1;
    end else begin
      cnt_nxt = 2'd1;  // new primitive opens a run
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cont_tx <= '0;
      run_cnt <= 2'd0;
    end else if (phy_ready) begin
      cont_tx <= tx_nxt;
      run_cnt <= cnt_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (phy_ready) begin
      prev_prim <= ll_tx.data;
    end
  end

endmodule

//--- hw/cont_rx_detect.sv
// receive stage that flags each primitive, expands CONT runs and reports X_RDY collisions
module cont_rx_detect (
  input  logic                       clk,
  input  logic                       rst,
  input  sata_link_pkg::link_dword_t rx,
  input  sata_link_pkg::link_dword_t ll_tx,  // own transmit dword, for the collision check
  output sata_link_pkg::prim_detect_t detect
);

  import sata_prim_pkg::*;
  import sata_link_pkg::*;

  logic [31:0]  prev_prim;  // last primitive other than CONT or ALIGN
  logic         prev_ok;
  logic [31:0]  held_prim;  // primitive being continued
  logic         held_ok;
  logic         cont_seen;  // CONT received during this hold

  logic         is_prim;
  logic         prim_other;
  logic         repeat_hit;
  logic         expand;
  logic         tx_xrdy;

  prim_detect_t lit;
  prim_detect_t det_nxt;

  // literal flags for one dword, collision flag left clear
  function automatic prim_detect_t decode(input logic [31:0] d);
    prim_detect_t f;
    f         = '0;
    f.sync    = (d == prim_sync);
    f.r_rdy   = (d == prim_r_rdy);
    f.r_ip    = (d == prim_r_ip);
    f.r_err   = (d == prim_r_err);
    f.r_ok    = (d == prim_r_ok);
    f.x_rdy   = (d == prim_x_rdy);
    f.sof     = (d == prim_sof);
    f.eof     = (d == prim_eof);
    f.wtrm    = (d == prim_wtrm);
    f.cont    = (d == prim_cont);
    f.hold    = (d == prim_hold);
    f.holda   = (d == prim_holda);
    f.pmreq_s = (d == prim_pmreq_s);
    f.pmreq_p = (d == prim_pmreq_p);
    f.align   = (d == prim_align);
    return f;
  endfunction

  assign is_prim    = rx.isk[0];
  assign lit        = is_prim ? decode(rx.data) : '0;
  assign prim_other = is_prim && !lit.cont && !lit.align;
  assign repeat_hit = prim_other && prev_ok && is_contable(rx.data) &&
                      (rx.data == prev_prim);

  // data only stands in for the held primitive once CONT has arrived
  assign expand  = held_ok && (lit.cont || lit.align || (!is_prim && cont_seen));
  assign tx_xrdy = ll_tx.isk[0] && (ll_tx.data == prim_x_rdy);

  always_comb begin
    det_nxt = lit;
    if (expand) begin
      det_nxt = det_nxt | decode(held_prim);
    end
    det_nxt.xrdy_xrdy = det_nxt.x_rdy && tx_xrdy;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      detect    <= '0;
      prev_ok   <= 1'b0;
      held_ok   <= 1'b0;
      cont_seen <= 1'b0;
    end else begin
      detect <= det_nxt;
      if (prim_other) begin
        prev_ok <= 1'b1;
        if (held_ok && (rx.data != held_prim)) begin
          held_ok   <= 1'b0;  // a new primitive ends the hold
          cont_seen <= 1'b0;
        end
        if (repeat_hit) begin
          held_ok <= 1'b1;
        end
      end else if (lit.cont) begin
        cont_seen <= held_ok;
      end else if (!is_prim) begin
        prev_ok <= 1'b0;
        if (!cont_seen) begin
          held_ok <= 1'b0;  // plain data without CONT
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prim_other) begin
      prev_prim <= rx.data;
    end
    if (repeat_hit) begin
      held_prim <= rx.data;
    end
  end

endmodule

//--- hw/sata_cont_top.sv
// CONT handling top level joining the transmit generator, its scrambler and the receive decoder
module sata_cont_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        phy_ready,
  input  logic                        xmit_cont_en,
  input  logic                        last_prim,
  input  sata_link_pkg::link_dword_t  ll_tx,
  input  sata_link_pkg::link_dword_t  rx,
  output sata_link_pkg::link_dword_t  cont_tx,
  output sata_link_pkg::prim_detect_t detect
);

  logic        scram_adv;
  logic [31:0] junk;

  cont_tx_gen tx_gen_i (
    .clk          (clk),
    .rst          (rst),
    .phy_ready    (phy_ready),
    .xmit_cont_en (xmit_cont_en),
    .last_prim    (last_prim),
    .ll_tx        (ll_tx),
    .junk         (junk),
    .scram_adv    (scram_adv),
    .cont_tx      (cont_tx)
  );

  cont_scrambler scram_i (
    .clk       (clk),
    .rst       (rst),
    .scram_adv (scram_adv),
    .junk      (junk)
  );

  cont_rx_detect rx_det_i (
    .clk    (clk),
    .rst    (rst),
    .rx     (rx),
    .ll_tx  (ll_tx),  // collision check sees the raw transmit dword
    .detect (detect)
  );

endmodule

//--- sim/sata_cont_props.sv
// concurrent assertions on the CONT transmit stage, bound into every cont_tx_gen
module sata_cont_props (
  input logic                       clk,
  input logic                       rst,
  input logic                       phy_ready,
  input logic                       xmit_cont_en,
  input logic                       scram_adv,
  input sata_link_pkg::link_dword_t ll_tx,
  input sata_link_pkg::link_dword_t cont_tx,
  input sata_link_pkg::link_dword_t tx_nxt
);

  timeunit 1ns;
  timeprecision 100ps;

  import sata_prim_pkg::*;
  import sata_link_pkg::*;

  link_dword_t acc_1;  // last dword taken by the phy
  link_dword_t acc_2;  // the one before it
  logic [1:0]  acc_n;  // dwords taken since reset, stops at 2

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_n <= 2'd0;
    end else if (phy_ready) begin
      acc_1 <= ll_tx;
      acc_2 <= acc_1;
      if (acc_n != 2'd2) begin
        acc_n <= acc_n + 2'd1;
      end
    end
  end

  // output frozen while the phy stalls
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    !phy_ready |=> $stable(cont_tx)) else $error("cont_tx moved while phy_ready low");

  // generated CONT needs the same primitive on the two dwords taken before it
  a_cont_after_two: assert property (@(posedge clk) disable iff (rst)
    (phy_ready && tx_nxt.data == prim_cont && ll_tx.data != prim_cont) |->
      (acc_n == 2'd2 && ll_tx.isk[0] && acc_1 == ll_tx && acc_2 == ll_tx))
    else $error("CONT sent without two identical primitives before it");

  a_no_adv_disabled: assert property (@(posedge clk) disable iff (rst)
    !xmit_cont_en |-> !scram_adv) else $error("scrambler advanced with CONT disabled");

endmodule

bind cont_tx_gen sata_cont_props props_i (
  .clk          (clk),
  .rst          (rst),
  .phy_ready    (phy_ready),
  .xmit_cont_en (xmit_cont_en),
  .scram_adv    (scram_adv),
  .ll_tx        (ll_tx),
  .cont_tx      (cont_tx),
  .tx_nxt       (tx_nxt)
);

//--- sim/cont_checker.sv
// checker for the CONT testbench, compares DUT outputs with the table one cycle after each row
module cont_checker #(
  parameter int n_rows = 56
) (
  input  logic                        clk,
  input  logic                        rst,
  input  int                          row_idx,
  input  logic                        row_valid,
  input  sata_link_pkg::link_dword_t  cont_tx,
  input  sata_link_pkg::prim_detect_t detect,
  input  logic [1:0]                  exp_kind [n_rows],
  input  sata_link_pkg::link_dword_t  exp_tx [n_rows],
  input  sata_link_pkg::prim_detect_t exp_det [n_rows],
  output int                          tx_errs,
  output int                          det_errs
);

  timeunit 1ns;
  timeprecision 100ps;

  import sata_prim_pkg::*;
  import sata_link_pkg::*;

  localparam logic [1:0] k_junk = 2'd2;
  localparam logic [1:0] k_hold = 2'd3;

  int          tx_cnt = 0;
  int          det_cnt = 0;
  int          cap_idx;
  logic        cap_valid = 1'b0;
  logic        in_reset = 1'b0;
  link_dword_t last_tx = '0;  // output seen one cycle earlier

  assign tx_errs  = tx_cnt;
  assign det_errs = det_cnt;

  // row that the DUT registered at this edge
  always @(posedge clk) begin
    cap_idx   <= row_idx;
    cap_valid <= row_valid;
    in_reset  <= rst;
  end

  // outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    if (in_reset) begin
      if (cont_tx !== '0) begin
        tx_cnt++;
        $display("Mismatch at %0t: cont_tx expected %h got %h", $time, 36'h0, cont_tx);
      end
      if (detect !== '0) begin
        det_cnt++;
        $display("Mismatch at %0t: detect expected %h got %h", $time, 16'h0, detect);
      end
    end else if (cap_valid) begin
      case (exp_kind[cap_idx])
        k_hold: begin
          if (cont_tx !== last_tx) begin
            tx_cnt++;
            $display("Mismatch at %0t: cont_tx expected %h got %h (row %0d)",
                     $time, last_tx, cont_tx, cap_idx);
          end
        end
        k_junk: begin
          if (cont_tx.isk !== 4'b0000) begin
            tx_cnt++;
            $display("Mismatch at %0t: cont_tx.isk expected %h got %h (row %0d)",
                     $time, 4'h0, cont_tx.isk, cap_idx);
          end
          if (cont_tx.data === exp_tx[cap_idx].data || cont_tx.data === prim_cont) begin
            tx_cnt++;
            $display("Mismatch at %0t: cont_tx.data expected junk not %h got %h (row %0d)",
                     $time, exp_tx[cap_idx].data, cont_tx.data, cap_idx);
          end
        end
        default: begin
          if (cont_tx !== exp_tx[cap_idx]) begin
            tx_cnt++;
            $display("Mismatch at %0t: cont_tx expected %h got %h (row %0d)",
                     $time, exp_tx[cap_idx], cont_tx, cap_idx);
          end
        end
      endcase
      if (detect !== exp_det[cap_idx]) begin
        det_cnt++;
        $display("Mismatch at %0t: detect expected %h got %h (row %0d)",
                 $time, exp_det[cap_idx], detect, cap_idx);
      end
    end
    last_tx = cont_tx;
  end

endmodule

//--- sim/tb_sata_cont.sv
// testbench for sata_cont_top, applies a table of tx and rx dwords one row per clock
module tb_sata_cont;

  timeunit 1ns;
  timeprecision 100ps;

  import sata_prim_pkg::*;
  import sata_link_pkg::*;

  localparam int n_rows = 56;
  localparam logic [1:0] k_pass = 2'd0;
  localparam logic [1:0] k_cont = 2'd1;
  localparam logic [1:0] k_junk = 2'd2;
  localparam logic [1:0] k_hold = 2'd3;  // phy not ready, output frozen

  logic         clk;
  logic         rst;
  logic         phy_ready;
  logic         xmit_cont_en;
  logic         last_prim;
  link_dword_t  ll_tx;
  link_dword_t  rx;
  link_dword_t  cont_tx;
  prim_detect_t detect;

  // stimulus and expected values, one entry per row
  link_dword_t  row_ll   [n_rows];
  link_dword_t  row_rx   [n_rows];
  logic         row_last [n_rows];
  logic         row_rdy  [n_rows];
  logic         row_en   [n_rows];
  logic [1:0]   exp_kind [n_rows];
  link_dword_t  exp_tx   [n_rows];
  prim_detect_t exp_det  [n_rows];

  int   n_filled = 0;
  int   row_idx;
  logic row_valid;
  int   tx_errs;
  int   det_errs;
  int   table_errs = 0;

  sata_cont_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .phy_ready    (phy_ready),
    .xmit_cont_en (xmit_cont_en),
    .last_prim    (last_prim),
    .ll_tx        (ll_tx),
    .rx           (rx),
    .cont_tx      (cont_tx),
    .detect       (detect)
  );

  cont_checker #(.n_rows(n_rows)) chk_i (
    .clk       (clk),
    .rst       (rst),
    .row_idx   (row_idx),
    .row_valid (row_valid),
    .cont_tx   (cont_tx),
    .detect    (detect),
    .exp_kind  (exp_kind),
    .exp_tx    (exp_tx),
    .exp_det   (exp_det),
    .tx_errs   (tx_errs),
    .det_errs  (det_errs)
  );

  always #50 clk = ~clk;

  function automatic link_dword_t prim(input logic [31:0] d);
    link_dword_t w;
    w.data = d;
    w.isk  = 4'b0001;
    return w;
  endfunction

  function automatic link_dword_t filler();
    link_dword_t w;
    w.data = $urandom();
    w.isk  = 4'b0000;  // plain data
    return w;
  endfunction

  // expected flag for a single received primitive
  function automatic prim_detect_t flag_for(input logic [31:0] p);
    prim_detect_t f;
    f = '0;
    case (p)
      prim_sync:    f.sync    = 1'b1;
      prim_r_rdy:   f.r_rdy   = 1'b1;
      prim_r_ip:    f.r_ip    = 1'b1;
      prim_r_err:   f.r_err   = 1'b1;
      prim_r_ok:    f.r_ok    = 1'b1;
      prim_x_rdy:   f.x_rdy   = 1'b1;
      prim_sof:     f.sof     = 1'b1;
      prim_eof:     f.eof     = 1'b1;
      prim_wtrm:    f.wtrm    = 1'b1;
      prim_cont:    f.cont    = 1'b1;
      prim_hold:    f.hold    = 1'b1;
      prim_holda:   f.holda   = 1'b1;
      prim_pmreq_s: f.pmreq_s = 1'b1;
      prim_pmreq_p: f.pmreq_p = 1'b1;
      prim_align:   f.align   = 1'b1;
      default:      f = '0;
    endcase
    return f;
  endfunction

  task automatic add_row(input link_dword_t ll, input link_dword_t r, input logic last,
                         input logic rdy, input logic en, input logic [1:0] kind,
                         input prim_detect_t det);
    if (n_filled >= n_rows) begin
      table_errs++;
      $display("stimulus table overflow at row %0d", n_filled);
      return;
    end
    row_ll[n_filled]   = ll;
    row_rx[n_filled]   = r;
    row_last[n_filled] = last;
    row_rdy[n_filled]  = rdy;
    row_en[n_filled]   = en;
    exp_kind[n_filled] = kind;
    exp_tx[n_filled]   = (kind == k_cont) ? prim(prim_cont) : ll;
    exp_det[n_filled]  = det;
    n_filled++;
  endtask

  // tx rows with plain data on rx
  task automatic tx_row(input logic [31:0] p, input logic last, input logic rdy,
                        input logic en, input logic [1:0] kind);
    add_row(prim(p), filler(), last, rdy, en, kind, '0);
  endtask

  task automatic build_table();
    prim_detect_t d;
    logic [31:0]  lit [15];
    lit = '{prim_sync, prim_r_rdy, prim_r_ip, prim_r_ok, prim_r_err, prim_x_rdy, prim_sof,
            prim_eof, prim_wtrm, prim_cont, prim_hold, prim_holda, prim_pmreq_s,
            prim_pmreq_p, prim_align};
    // six SYNC: two pass, CONT, then junk
    tx_row(prim_sync, 0, 1, 1, k_pass);
    tx_row(prim_sync, 0, 1, 1, k_pass);
    tx_row(prim_sync, 0, 1, 1, k_cont);
    tx_row(prim_sync, 0, 1, 1, k_junk);
    tx_row(prim_sync, 0, 1, 1, k_junk);
    tx_row(prim_sync, 0, 1, 1, k_junk);
    tx_row(prim_r_ok, 0, 1, 1, k_pass);  // new primitive restarts the run
    tx_row(prim_r_ok, 0, 1, 1, k_pass);
    tx_row(prim_r_ok, 1, 1, 1, k_pass);  // last_prim cuts the run
    tx_row(prim_r_ok, 0, 1, 1, k_pass);
    tx_row(prim_r_ok, 0, 1, 1, k_pass);
    tx_row(prim_r_ok, 0, 1, 1, k_cont);
    repeat (4) tx_row(prim_sof, 0, 1, 1, k_pass);  // never continued
    repeat (4) tx_row(prim_hold, 0, 1, 0, k_pass);  // CONT disabled
    // back-pressure in the middle of a WTRM run
    tx_row(prim_wtrm, 0, 1, 1, k_pass);
    tx_row(prim_wtrm, 0, 0, 1, k_hold);
    tx_row(prim_wtrm, 0, 1, 1, k_pass);
    tx_row(prim_wtrm, 0, 0, 1, k_hold);
    tx_row(prim_wtrm, 0, 0, 1, k_hold);
    tx_row(prim_wtrm, 0, 1, 1, k_cont);
    // literal decode of every primitive
    for (int i = 0; i < 15; i++) begin
      add_row(filler(), prim(lit[i]), 0, 1, 1, k_pass, flag_for(lit[i]));
    end
    // CONT expansion of a HOLD run
    add_row(filler(), prim(prim_hold), 0, 1, 1, k_pass, flag_for(prim_hold));
    add_row(filler(), prim(prim_hold), 0, 1, 1, k_pass, flag_for(prim_hold));
    d = flag_for(prim_hold) | flag_for(prim_cont);
    add_row(filler(), prim(prim_cont), 0, 1, 1, k_pass, d);
    add_row(filler(), filler(), 0, 1, 1, k_pass, flag_for(prim_hold));
    d = flag_for(prim_hold) | flag_for(prim_align);
    add_row(filler(), prim(prim_align), 0, 1, 1, k_pass, d);
    add_row(filler(), filler(), 0, 1, 1, k_pass, flag_for(prim_hold));
    add_row(filler(), prim(prim_r_ok), 0, 1, 1, k_pass, flag_for(prim_r_ok));
    add_row(filler(), filler(), 0, 1, 1, k_pass, '0);
    // X_RDY from both sides, tx CONT off so ll_tx passes
    d = flag_for(prim_x_rdy);
    d.xrdy_xrdy = 1'b1;
    add_row(prim(prim_x_rdy), prim(prim_x_rdy), 0, 1, 0, k_pass, d);
    add_row(prim(prim_x_rdy), prim(prim_x_rdy), 0, 1, 0, k_pass, d);
    add_row(prim(prim_x_rdy), prim(prim_cont), 0, 1, 0, k_pass, d | flag_for(prim_cont));
    add_row(prim(prim_x_rdy), filler(), 0, 1, 0, k_pass, d);
    add_row(prim(prim_sync), filler(), 0, 1, 0, k_pass, flag_for(prim_x_rdy));
    add_row(filler(), filler(), 0, 1, 0, k_pass, flag_for(prim_x_rdy));
    add_row(filler(), prim(prim_sync), 0, 1, 1, k_pass, flag_for(prim_sync));
    if (n_filled != n_rows) begin
      table_errs++;
      $display("stimulus table has %0d rows, %0d expected", n_filled, n_rows);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    phy_ready    = 1'b0;
    xmit_cont_en = 1'b0;
    last_prim    = 1'b0;
    ll_tx        = '0;
    rx           = '0;
    row_idx      = 0;
    row_valid    = 1'b0;
    void'($urandom(32'hbc44_09bf));
    build_table();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #1;
      ll_tx        = row_ll[i];
      rx           = row_rx[i];
      last_prim    = row_last[i];
      phy_ready    = row_rdy[i];
      xmit_cont_en = row_en[i];
      row_idx      = i;
      row_valid    = 1'b1;
    end
    @(posedge clk);
    #1 row_valid = 1'b0;
    repeat (2) @(posedge clk);
    $display("errors: tx %0d, detect %0d, table %0d", tx_errs, det_errs, table_errs);
    if (tx_errs + det_errs + table_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, sized from the table length plus reset and drain cycles
  initial begin
    #((n_rows + 20) * 100);
    $display("run timed out before the stimulus table finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- all.f
hw/sata_prim_pkg.sv
hw/sata_link_pkg.sv
hw/cont_scrambler.sv
hw/cont_tx_gen.sv
hw/cont_rx_detect.sv
hw/sata_cont_top.sv
sim/sata_cont_props.sv
sim/cont_checker.sv
sim/tb_sata_cont.sv

//--- Makefile
# Verilator build and run of the CONT testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_cont
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
